// File: src/dma_pkg.sv
`default_nettype none

package dma_pkg;

    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;

    // Configuration window, one 256-byte page
    localparam logic [ADDR_W-1:0] CFG_BASE = 32'h3000_0000;

    localparam logic [7:0] REG_CTRL   = 8'h00;
    localparam logic [7:0] REG_SRC    = 8'h04;
    localparam logic [7:0] REG_DST    = 8'h08;
    localparam logic [7:0] REG_LEN    = 8'h10;
    localparam logic [7:0] REG_STATUS = 8'h14;
    localparam logic [7:0] REG_DATA   = 8'h18;

    localparam int STAT_IN_FULL  = 0;
    localparam int STAT_OUT_FULL = 1;
    localparam int STAT_BUSY     = 2;

    localparam int MEM_WORDS = 256;
    localparam int MEM_AW    = $clog2(MEM_WORDS);

    typedef struct packed {
        logic              cyc;
        logic              stb;
        logic              we;
        logic [3:0]        sel;
        logic [ADDR_W-1:0] adr;
        logic [DATA_W-1:0] dat;
    } wb_req_t;

    typedef struct packed {
        logic              ack;
        logic [DATA_W-1:0] dat;
    } wb_rsp_t;

    typedef enum logic [1:0] {
        DMA_IDLE,
        DMA_ARB,
        DMA_FETCH,
        DMA_STORE
    } dma_state_t;

    typedef enum logic [1:0] {
        ARB_FREE,
        ARB_HOST,
        ARB_DMA
    } arb_state_t;

endpackage

`default_nettype wire

// File: src/dma_mailbox.sv
`default_nettype none

module dma_mailbox
    import dma_pkg::*;
(
    input  wire logic    wb_clk_i,
    input  wire logic    wb_rst_i,
    input  wire wb_req_t cfg_req_i,
    output wb_rsp_t      cfg_rsp_o,
    output wb_req_t      dma_req_o,
    input  wire wb_rsp_t dma_rsp_i
);

    dma_state_t        state_q;
    logic [DATA_W-1:0] src_q;
    logic [DATA_W-1:0] dst_q;
    logic [DATA_W-1:0] len_q;
    logic [DATA_W-1:0] fetch_cnt_q;
    logic [DATA_W-1:0] store_cnt_q;
    logic [DATA_W-1:0] store_next;
    logic [DATA_W-1:0] in_buf_q;
    logic [DATA_W-1:0] out_buf_q;
    logic [DATA_W-1:0] rdata_q;
    logic [DATA_W-1:0] rd_mux;
    logic [DATA_W-1:0] status;
    logic              in_full_q;
    logic              out_full_q;
    logic              ack_q;
    logic [7:0]        cfg_off;
    logic              cfg_hit;
    logic              cfg_ready;
    logic              cfg_go;
    logic              cfg_wr;
    logic              data_pop;
    logic              data_push;
    logic              start;
    logic              busy;
    logic              fetch_done;
    logic              store_done;

    assign busy    = (state_q != DMA_IDLE);
    assign cfg_off = cfg_req_i.adr[7:0];
    assign cfg_hit = cfg_req_i.cyc && cfg_req_i.stb &&
                     (cfg_req_i.adr[ADDR_W-1:8] == CFG_BASE[ADDR_W-1:8]);

    // Data register waits on the buffer it touches
    always_comb begin
        cfg_ready = 1'b1;
        if (cfg_off == REG_DATA) begin
            cfg_ready = cfg_req_i.we ? !out_full_q : in_full_q;
        end
    end

    assign cfg_go    = cfg_hit && !ack_q && cfg_ready;
    assign cfg_wr    = cfg_go && cfg_req_i.we;
    assign data_pop  = cfg_go && !cfg_req_i.we && (cfg_off == REG_DATA);
    assign data_push = cfg_wr && (cfg_off == REG_DATA);
    assign start     = cfg_wr && (cfg_off == REG_CTRL) && cfg_req_i.dat[0] &&
                       !busy && (len_q != '0);

    assign fetch_done = (state_q == DMA_FETCH) && dma_rsp_i.ack;
    assign store_done = (state_q == DMA_STORE) && dma_rsp_i.ack;
    assign store_next = store_cnt_q + 1'b1;

    always_comb begin
        status                = '0;
        status[STAT_IN_FULL]  = in_full_q;
        status[STAT_OUT_FULL] = out_full_q;
        status[STAT_BUSY]     = busy;
    end

    always_comb begin
        case (cfg_off)
            REG_SRC:    rd_mux = src_q;
            REG_DST:    rd_mux = dst_q;
            REG_LEN:    rd_mux = len_q;
            REG_STATUS: rd_mux = status;
            REG_DATA:   rd_mux = in_buf_q;
            default:    rd_mux = '0;
        endcase
    end

    always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
        if (wb_rst_i) begin
            src_q      <= '0;
            dst_q      <= '0;
            len_q      <= '0;
            in_full_q  <= 1'b0;
            out_full_q <= 1'b0;
            ack_q      <= 1'b0;
        end else begin
            ack_q <= cfg_go;
            // Setup registers are frozen during a transfer
            if (cfg_wr && !busy) begin
                case (cfg_off)
                    REG_SRC: src_q <= cfg_req_i.dat;
                    REG_DST: dst_q <= cfg_req_i.dat;
                    REG_LEN: len_q <= cfg_req_i.dat;
                    default: ;
                endcase
            end
            if (fetch_done) begin
                in_full_q <= 1'b1;
            end else if (data_pop) begin
                in_full_q <= 1'b0;
            end
            if (data_push) begin
                out_full_q <= 1'b1;
            end else if (store_done) begin
                out_full_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge wb_clk_i) begin
        if (cfg_go) begin
            rdata_q <= rd_mux;
        end
        if (fetch_done) begin
            in_buf_q <= dma_rsp_i.dat;
        end
        if (data_push) begin
            out_buf_q <= cfg_req_i.dat;
        end
    end

    // Memory-side sequencer, fetch before store
    always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
        if (wb_rst_i) begin
            state_q     <= DMA_IDLE;
            fetch_cnt_q <= '0;
            store_cnt_q <= '0;
        end else begin
            case (state_q)
                DMA_IDLE: begin
                    if (start) begin
                        fetch_cnt_q <= '0;
                        store_cnt_q <= '0;
                        state_q     <= DMA_ARB;
                    end
                end
                DMA_ARB: begin
                    if (!in_full_q && (fetch_cnt_q < len_q)) begin
                        state_q <= DMA_FETCH;
                    end else if (out_full_q) begin
                        state_q <= DMA_STORE;
                    end
                end
                DMA_FETCH: begin
                    if (dma_rsp_i.ack) begin
                        fetch_cnt_q <= fetch_cnt_q + 1'b1;
                        state_q     <= DMA_ARB;
                    end
                end
                DMA_STORE: begin
                    if (dma_rsp_i.ack) begin
                        store_cnt_q <= store_next;
                        state_q     <= (store_next == len_q) ? DMA_IDLE : DMA_ARB;
                    end
                end
                default: state_q <= DMA_IDLE;
            endcase
        end
    end

    always_comb begin
        dma_req_o     = '0;
        dma_req_o.cyc = (state_q == DMA_FETCH) || (state_q == DMA_STORE);
        dma_req_o.stb = dma_req_o.cyc;
        dma_req_o.we  = (state_q == DMA_STORE);
        dma_req_o.sel = 4'hF;
        dma_req_o.dat = out_buf_q;
        if (state_q == DMA_STORE) begin
            dma_req_o.adr = dst_q + {store_cnt_q[DATA_W-3:0], 2'b00};
        end else begin
            dma_req_o.adr = src_q + {fetch_cnt_q[DATA_W-3:0], 2'b00};
        end
    end

    assign cfg_rsp_o.ack = ack_q;
    assign cfg_rsp_o.dat = rdata_q;

endmodule

`default_nettype wire

// File: src/wb_arbiter.sv
`default_nettype none

module wb_arbiter
    import dma_pkg::*;
(
    input  wire logic    wb_clk_i,
    input  wire logic    wb_rst_i,
    input  wire wb_req_t host_req_i,
    output wb_rsp_t      host_rsp_o,
    input  wire wb_req_t dma_req_i,
    output wb_rsp_t      dma_rsp_o,
    output wb_req_t      mem_req_o,
    input  wire wb_rsp_t mem_rsp_i
);

    arb_state_t arb_q;
    arb_state_t arb_d;
    logic       host_act;
    logic       dma_act;
    logic       sel_host;
    logic       sel_dma;

    assign host_act = host_req_i.cyc && host_req_i.stb;
    assign dma_act  = dma_req_i.cyc && dma_req_i.stb;

    // Same-cycle grant from free, host first
    always_comb begin
        sel_host = 1'b0;
        sel_dma  = 1'b0;
        case (arb_q)
            ARB_FREE: begin
                if (host_act) begin
                    sel_host = 1'b1;
                end else if (dma_act) begin
                    sel_dma = 1'b1;
                end
            end
            ARB_HOST: sel_host = 1'b1;
            ARB_DMA:  sel_dma  = 1'b1;
            default:  ;
        endcase
    end

    always_comb begin
        if (mem_rsp_i.ack) begin
            arb_d = ARB_FREE;
        end else if (sel_host && host_req_i.cyc) begin
            arb_d = ARB_HOST;
        end else if (sel_dma && dma_req_i.cyc) begin
            arb_d = ARB_DMA;
        end else begin
            arb_d = ARB_FREE;
        end
    end

    always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
        if (wb_rst_i) begin
            arb_q <= ARB_FREE;
        end else begin
            arb_q <= arb_d;
        end
    end

    always_comb begin
        if (sel_host) begin
            mem_req_o = host_req_i;
        end else if (sel_dma) begin
            mem_req_o = dma_req_i;
        end else begin
            mem_req_o = '0;
        end
    end

    // Waiting master sees no ack
    assign host_rsp_o.ack = mem_rsp_i.ack && sel_host;
    assign host_rsp_o.dat = mem_rsp_i.dat;
    assign dma_rsp_o.ack  = mem_rsp_i.ack && sel_dma;
    assign dma_rsp_o.dat  = mem_rsp_i.dat;

endmodule

`default_nettype wire

// File: src/wb_sram.sv
`default_nettype none

module wb_sram
    import dma_pkg::*;
(
    input  wire logic    wb_clk_i,
    input  wire logic    wb_rst_i,
    input  wire wb_req_t mem_req_i,
    output wb_rsp_t      mem_rsp_o
);

    logic [DATA_W-1:0] mem [MEM_WORDS];
    logic [DATA_W-1:0] rdata_q;
    logic [MEM_AW-1:0] idx;
    logic              ack_q;
    logic              go;

    // Word index, upper address bits ignored
    assign idx = mem_req_i.adr[MEM_AW+1:2];
    assign go  = mem_req_i.cyc && mem_req_i.stb && !ack_q;

    always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
        if (wb_rst_i) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= go;
        end
    end

    always_ff @(posedge wb_clk_i) begin
        if (go) begin
            rdata_q <= mem[idx];
            if (mem_req_i.we) begin
                for (int i = 0; i < 4; i++) begin
                    if (mem_req_i.sel[i]) begin
                        mem[idx][8*i +: 8] <= mem_req_i.dat[8*i +: 8];
                    end
                end
            end
        end
    end

    assign mem_rsp_o.ack = ack_q;
    assign mem_rsp_o.dat = rdata_q;

endmodule

`default_nettype wire

// File: src/dma_subsys.sv
`default_nettype none

module dma_subsys
    import dma_pkg::*;
(
    input  wire logic    wb_clk_i,
    input  wire logic    wb_rst_i,
    input  wire wb_req_t cfg_req_i,
    output wb_rsp_t      cfg_rsp_o,
    input  wire wb_req_t host_req_i,
    output wb_rsp_t      host_rsp_o
);

    wb_req_t dma_req;
    wb_rsp_t dma_rsp;
    wb_req_t mem_req;
    wb_rsp_t mem_rsp;

    dma_mailbox dma_mailbox_inst (
        .wb_clk_i  (wb_clk_i),
        .wb_rst_i  (wb_rst_i),
        .cfg_req_i (cfg_req_i),
        .cfg_rsp_o (cfg_rsp_o),
        .dma_req_o (dma_req),
        .dma_rsp_i (dma_rsp)
    );

    // Host and DMA share the memory
    wb_arbiter wb_arbiter_inst (
        .wb_clk_i   (wb_clk_i),
        .wb_rst_i   (wb_rst_i),
        .host_req_i (host_req_i),
        .host_rsp_o (host_rsp_o),
        .dma_req_i  (dma_req),
        .dma_rsp_o  (dma_rsp),
        .mem_req_o  (mem_req),
        .mem_rsp_i  (mem_rsp)
    );

    wb_sram wb_sram_inst (
        .wb_clk_i  (wb_clk_i),
        .wb_rst_i  (wb_rst_i),
        .mem_req_i (mem_req),
        .mem_rsp_o (mem_rsp)
    );

endmodule

`default_nettype wire

// File: dv/tb_clock.sv
`default_nettype none

module tb_clock (
    output logic clk_o,
    output logic rst_o
);

    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        clk_o = 1'b0;
        forever #5 clk_o = ~clk_o;
    end

    // Reset held over four rising edges
    initial begin
        rst_o = 1'b1;
        repeat (4) @(posedge clk_o);
        #1;
        rst_o = 1'b0;
    end

endmodule

`default_nettype wire

// File: dv/tb_dma_subsys.sv
`default_nettype none

module tb_dma_subsys
    import dma_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int MAX_LEN      = 24;
    localparam int HOST_OPS     = 16;
    localparam int XFERS        = 2;
    localparam int HOST_LO      = 200;
    localparam int CYC_PER_WORD = 40;
    // Fill, three sweeps, every transfer word twice, host traffic, register setup
    localparam int TOTAL_WORDS  = 4 * MEM_WORDS + XFERS * (2 * MAX_LEN + 2 * HOST_OPS) + 64;
    localparam int TIMEOUT_NS   = TOTAL_WORDS * CYC_PER_WORD * 10;

    logic              wb_clk;
    logic              wb_rst;
    wb_req_t           cfg_req;
    wb_rsp_t           cfg_rsp;
    wb_req_t           host_req;
    wb_rsp_t           host_rsp;
    logic [DATA_W-1:0] model_mem [MEM_WORDS];
    int                seed;

    tb_clock tb_clock_inst (
        .clk_o (wb_clk),
        .rst_o (wb_rst)
    );

    dma_subsys dma_subsys_inst (
        .wb_clk_i   (wb_clk),
        .wb_rst_i   (wb_rst),
        .cfg_req_i  (cfg_req),
        .cfg_rsp_o  (cfg_rsp),
        .host_req_i (host_req),
        .host_rsp_o (host_rsp)
    );

    function automatic int pick_below(input int n);
        logic [31:0] r;
        r = $random(seed);
        return int'(r % 32'(n));
    endfunction

    // Initial memory image with every byte tied to the word index
    function automatic logic [DATA_W-1:0] fill_word(input int i);
        return {8'(i) ^ 8'h5A, ~8'(i), 8'(i), 8'(i * 7 + 3)};
    endfunction

    function automatic logic [DATA_W-1:0] merge_bytes(input logic [DATA_W-1:0] old_w,
                                                      input logic [DATA_W-1:0] new_w,
                                                      input logic [3:0] sel);
        logic [DATA_W-1:0] res;
        res = old_w;
        for (int b = 0; b < 4; b++) begin
            if (sel[b]) begin
                res[8*b +: 8] = new_w[8*b +: 8];
            end
        end
        return res;
    endfunction

    task automatic check_word(input string name, input logic [DATA_W-1:0] got,
                              input logic [DATA_W-1:0] exp);
        assert (got === exp) else begin
            $display("[FAIL] %s got %h expected %h", name, got, exp);
            $display("=== FAIL ===");
            $fatal(1, "Mismatch on %s", name);
        end
    endtask

    // One classic Wishbone cycle that starts and ends 1 ns after a rising edge
    task automatic bus_access(input bit host, input logic we, input logic [ADDR_W-1:0] adr,
                              input logic [DATA_W-1:0] wdata, input logic [3:0] sel,
                              output logic [DATA_W-1:0] rdata);
        wb_req_t req;
        req.cyc = 1'b1;
        req.stb = 1'b1;
        req.we  = we;
        req.sel = sel;
        req.adr = adr;
        req.dat = wdata;
        if (host) begin
            host_req = req;
        end else begin
            cfg_req = req;
        end
        do begin
            @(negedge wb_clk);
        end while (!(host ? host_rsp.ack : cfg_rsp.ack));
        rdata = host ? host_rsp.dat : cfg_rsp.dat;
        @(posedge wb_clk);
        #1;
        if (host) begin
            host_req = '0;
        end else begin
            cfg_req = '0;
        end
    endtask

    task automatic cfg_write(input logic [7:0] off, input logic [DATA_W-1:0] data);
        logic [DATA_W-1:0] unused;
        bus_access(1'b0, 1'b1, CFG_BASE | ADDR_W'(off), data, 4'hF, unused);
    endtask

    task automatic cfg_read(input logic [7:0] off, output logic [DATA_W-1:0] data);
        bus_access(1'b0, 1'b0, CFG_BASE | ADDR_W'(off), '0, 4'hF, data);
    endtask

    task automatic host_write(input int idx, input logic [DATA_W-1:0] data,
                              input logic [3:0] sel);
        logic [DATA_W-1:0] unused;
        bus_access(1'b1, 1'b1, ADDR_W'(idx * 4), data, sel, unused);
    endtask

    task automatic host_read(input int idx, output logic [DATA_W-1:0] data);
        bus_access(1'b1, 1'b0, ADDR_W'(idx * 4), '0, 4'hF, data);
    endtask

    task automatic idle_cycles(input int n);
        for (int k = 0; k < n; k++) begin
            @(posedge wb_clk);
            #1;
        end
    endtask

    task automatic reg_readback(input logic [7:0] off, input string name);
        logic [DATA_W-1:0] val;
        logic [DATA_W-1:0] rd;
        val = $random(seed);
        cfg_write(off, val);
        cfg_read(off, rd);
        check_word(name, rd, val);
    endtask

    // Pop each word, transform it as the accelerator would and push it back
    task automatic run_transfer(input int src_idx, input int dst_idx, input int len);
        logic [DATA_W-1:0] key;
        logic [DATA_W-1:0] w;
        logic [DATA_W-1:0] rd;
        key = $random(seed);
        cfg_write(REG_SRC, ADDR_W'(src_idx * 4));
        cfg_write(REG_DST, ADDR_W'(dst_idx * 4));
        cfg_write(REG_LEN, DATA_W'(len));
        cfg_write(REG_CTRL, 32'h1);
        // No store can finish before the first push
        cfg_read(REG_STATUS, rd);
        check_word("cfg_rsp.dat STAT_BUSY after start", DATA_W'(rd[STAT_BUSY]), 32'h1);
        for (int i = 0; i < len; i++) begin
            cfg_read(REG_DATA, w);
            check_word("cfg_rsp.dat REG_DATA", w, model_mem[src_idx + i]);
            model_mem[dst_idx + i] = (w ^ key) + DATA_W'(i);
            cfg_write(REG_DATA, model_mem[dst_idx + i]);
        end
        do begin
            cfg_read(REG_STATUS, rd);
        end while (rd[STAT_BUSY]);
        check_word("cfg_rsp.dat REG_STATUS after transfer", rd, 32'h0);
    endtask

    // Host traffic confined to the top of memory
    task automatic host_traffic(input int n);
        int                idx;
        logic [31:0]       r;
        logic [DATA_W-1:0] wdata;
        logic [DATA_W-1:0] rd;
        for (int k = 0; k < n; k++) begin
            idx   = HOST_LO + pick_below(MEM_WORDS - HOST_LO);
            r     = $random(seed);
            wdata = $random(seed);
            host_write(idx, wdata, r[3:0]);
            model_mem[idx] = merge_bytes(model_mem[idx], wdata, r[3:0]);
            idle_cycles(pick_below(3));
            host_read(idx, rd);
            check_word("host_rsp.dat host region", rd, model_mem[idx]);
        end
    endtask

    task automatic check_memory();
        logic [DATA_W-1:0] rd;
        for (int i = 0; i < MEM_WORDS; i++) begin
            host_read(i, rd);
            check_word($sformatf("host_rsp.dat mem[%0d]", i), rd, model_mem[i]);
        end
    endtask

    initial begin
        #(TIMEOUT_NS);
        $display("Timeout: the run did not finish within %0d ns", TIMEOUT_NS);
        $display("=== FAIL ===");
        $fatal(1, "Watchdog expired");
    end

    initial begin
        logic [DATA_W-1:0] rd;
        int                src_idx;
        int                dst_idx;
        int                len;
        seed     = 32'h02a2d5a8;
        cfg_req  = '0;
        host_req = '0;
        @(negedge wb_rst);
        @(posedge wb_clk);
        #1;

        cfg_read(REG_STATUS, rd);
        check_word("cfg_rsp.dat REG_STATUS after reset", rd, 32'h0);
        // Contents are unknown here so only the ack is awaited
        host_read(pick_below(MEM_WORDS), rd);
        reg_readback(REG_SRC, "cfg_rsp.dat REG_SRC");
        reg_readback(REG_DST, "cfg_rsp.dat REG_DST");
        reg_readback(REG_LEN, "cfg_rsp.dat REG_LEN");

        for (int i = 0; i < MEM_WORDS; i++) begin
            model_mem[i] = fill_word(i);
            host_write(i, model_mem[i], 4'hF);
        end

        for (int t = 0; t < XFERS; t++) begin
            len     = 1 + pick_below(MAX_LEN);
            src_idx = pick_below(64 - MAX_LEN);
            dst_idx = 80 + pick_below(64 - MAX_LEN);
            fork
                run_transfer(src_idx, dst_idx, len);
                host_traffic(HOST_OPS);
            join
            host_read(dst_idx + len, rd);
            check_word("host_rsp.dat past LEN", rd, model_mem[dst_idx + len]);
            check_memory();
        end

        cfg_write(REG_LEN, 32'h0);
        cfg_write(REG_CTRL, 32'h1);
        cfg_read(REG_STATUS, rd);
        check_word("cfg_rsp.dat REG_STATUS after zero LEN start", rd, 32'h0);
        check_memory();

        $display("=== PASS ===");
        $finish;
    end

endmodule

`default_nettype wire

// File: compile.f
src/dma_pkg.sv
src/dma_mailbox.sv
src/wb_arbiter.sv
src/wb_sram.sv
src/dma_subsys.sv
dv/tb_clock.sv
dv/tb_dma_subsys.sv

// File: Makefile
TOP := tb_dma_subsys

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check sim.log"
	@echo "  clean  remove obj_dir and sim.log"
	@echo "  help   show this list"

test:
	verilator --binary --timing -Wno-fatal -f compile.f --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP) 2>&1 | tee sim.log
	@if grep -qF "=== FAIL ===" sim.log; then echo "Simulation failed"; exit 1; fi
	@grep -qF "=== PASS ===" sim.log || (echo "Simulation ended without passing"; exit 1)

clean:
	rm -rf obj_dir sim.log
